// ==== data_mem_tests.txt ====
# op addr size sign value stalls: op is R or W, addr is hex, size 0 byte 1 half 2 word
# value is the write data for W and the expected load result for R, stalls in cycles
W 1000 2 0 11223344 2
W 1004 2 0 55667788 0
W 1008 2 0 99aabbcc 0
W 100c 2 0 ddeeff00 0
R 1000 2 0 11223344 0
R 100c 2 0 ddeeff00 0
W 1010 2 0 a5a5a5a5 2
W 1011 0 0 0000003c 0
W 1012 1 0 00008001 0
R 1010 2 0 80013ca5 0
R 1013 0 1 ffffff80 0
R 1013 0 0 00000080 0
R 1012 0 1 00000001 0
R 1011 0 1 0000003c 0
R 1010 0 1 ffffffa5 0
R 1012 1 1 ffff8001 0
R 1010 1 0 00003ca5 0
W 1020 2 0 c0c0c0c0 2
W 1030 2 0 d0d0d0d0 2
W 1040 2 0 e0e0e0e0 2
R 1004 2 0 55667788 2
R 1008 2 0 99aabbcc 0
R 1010 2 0 80013ca5 2
W 2000 2 0 000000c3 0
R 1020 2 0 c0c0c0c0 2

// ==== data_mem_cached.f ====
+incdir+.
mem_cache_pkg.sv
cache_line.sv
line_select.sv
line_backing_mem.sv
load_store_align.sv
cache_ctrl.sv
data_mem_cached.sv
data_mem_cached_checker.sv
tb_data_mem_cached.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_data_mem_cached \
	-f data_mem_cached.f -o sim_data_mem_cached

output=$(./obj_dir/sim_data_mem_cached)
echo "$output"

if echo "$output" | grep -qx "TESTS PASSED"; then
	exit 0
fi
exit 1

// ==== tb_data_mem_cached.sv ====
// Testbench for the cached data memory, driven by accesses read from a data file
`include "mem_cache_config.svh"

module tb_data_mem_cached;
	import mem_cache_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 8;
	localparam int CYCLES_PER_TEST = 5;

	typedef struct packed {
		mem_req_t req;
		word_t expect_data;
		logic [1:0] expect_stalls;
	} test_t;

	logic clk;
	logic rst_n;
	mem_req_t req;
	word_t read_data;
	logic stall;
	logic [7:0] led;

	test_t tests [$];
	logic [7:0] ref_mem [1 << 14];
	logic [7:0] expect_led;
	logic tests_loaded = 1'b0;
	bit load_ok;
	int error_count = 0;

	data_mem_cached uut (
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.read_data(read_data),
		.stall(stall),
		.led(led)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_word(input word_t actual, input word_t expected, input string what);
		if (actual !== expected) begin
			error_count++;
			$display("CHECK FAILED at %0t: %s read data %08h, expected %08h",
				$time, what, actual, expected);
		end
	endtask

	task automatic check_led(input logic [7:0] actual, input logic [7:0] expected,
		input string what);
		if (actual !== expected) begin
			error_count++;
			$display("CHECK FAILED at %0t: %s led %02h, expected %02h",
				$time, what, actual, expected);
		end
	endtask

	task automatic check_stall(input int actual, input int expected, input string what);
		if (actual != expected) begin
			error_count++;
			$display("CHECK FAILED at %0t: %s stalled %0d cycles, expected %0d",
				$time, what, actual, expected);
		end
	endtask

	function automatic int access_bytes(input access_size_e size);
		return (size == SIZE_BYTE) ? 1 : ((size == SIZE_HALF) ? 2 : 4);
	endfunction

	// Little-endian byte model, halfwords and words are aligned down to their size
	function automatic void model_store(input mem_req_t r);
		int nbytes;
		byte_addr_t base;
		nbytes = access_bytes(r.size);
		base = r.addr & ~byte_addr_t'(nbytes - 1);
		for (int i = 0; i < nbytes; i++) begin
			ref_mem[base + byte_addr_t'(i)] = r.write_data[i*8 +: 8];
		end
	endfunction

	function automatic word_t model_load(input mem_req_t r);
		int nbytes;
		byte_addr_t base;
		word_t value;
		nbytes = access_bytes(r.size);
		base = r.addr & ~byte_addr_t'(nbytes - 1);
		value = '0;
		for (int i = 0; i < nbytes; i++) begin
			value[i*8 +: 8] = ref_mem[base + byte_addr_t'(i)];
		end
		if (r.sign_ext && (nbytes < 4) && value[nbytes*8-1]) begin
			value = value | (~word_t'(0) << (nbytes * 8));
		end
		return value;
	endfunction

	// Lines whose first token starts with # are comments
	task automatic load_tests(output bit ok);
		int fd;
		int code;
		int size_code;
		int sign;
		int stalls;
		string op;
		string rest;
		byte_addr_t addr;
		word_t value;
		test_t t;
		ok = 1'b0;
		fd = $fopen("data_mem_tests.txt", "r");
		if (fd != 0) begin
			while ($fscanf(fd, "%s", op) == 1) begin
				if (op[0] == "#") begin
					code = $fgets(rest, fd);
				end else begin
					code = $fscanf(fd, "%h %d %d %h %d", addr, size_code, sign, value, stalls);
					t = '0;
					t.req.read = (op == "R");
					t.req.write = (op == "W");
					t.req.addr = addr;
					t.req.size = access_size_e'(size_code[1:0]);
					t.req.sign_ext = sign[0];
					t.req.write_data = value;
					t.expect_data = value;
					t.expect_stalls = stalls[1:0];
					tests.push_back(t);
				end
			end
			$fclose(fd);
			ok = 1'b1;
		end
	endtask

	// One request per access, held for one edge, then the stall is counted at falling edges
	task automatic run_access(input test_t t, input int index);
		int stall_cycles;
		string what;
		what = $sformatf("access %0d at %04h", index, t.req.addr);
		req = t.req;
		@(posedge clk);
		@(negedge clk);
		req.read = 1'b0;
		req.write = 1'b0;
		stall_cycles = 0;
		while (stall) begin
			stall_cycles++;
			@(negedge clk);
		end
		check_stall(stall_cycles, int'(t.expect_stalls), what);
		if (t.req.write && (t.req.addr == `LED_ADDR)) begin
			expect_led = t.req.write_data[7:0];
		end else if (t.req.write) begin
			model_store(t.req);
		end else begin
			check_word(read_data, model_load(t.req), what);
			check_word(read_data, t.expect_data, {what, " (file value)"});
		end
		check_led(led, expect_led, what);
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		req = '0;
		expect_led = '0;
		load_tests(load_ok);
		tests_loaded = 1'b1;
		if (!load_ok || (tests.size() == 0)) begin
			$display("Could not read any access from data_mem_tests.txt");
			$display("TESTS FAILED");
			$finish;
		end else begin
			repeat (RESET_CYCLES) @(posedge clk);
			@(negedge clk);
			rst_n = 1'b1;
			check_stall(int'(stall), 0, "after reset");
			check_led(led, 8'h00, "after reset");
			check_word(read_data, '0, "after reset");
			foreach (tests[i]) begin
				run_access(tests[i], i);
			end
			$display("Accesses run: %0d, errors: %0d", tests.size(), error_count);
			if (error_count == 0) begin
				$display("TESTS PASSED");
			end else begin
				$display("TESTS FAILED");
			end
			$finish;
		end
	end

	initial begin
		wait (tests_loaded);
		#((tests.size() * CYCLES_PER_TEST + RESET_CYCLES + 2) * CLK_PERIOD);
		$display("Timeout: the accesses did not complete in time, stall may be stuck high");
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== data_mem_cached_checker.sv ====
// Assertion checker for the cached data memory: reset state, stall length and LED updates
`include "mem_cache_config.svh"

module data_mem_cached_checker (
	input logic clk,
	input logic rst_n,
	input mem_cache_pkg::mem_req_t req,
	input logic stall,
	input logic [7:0] led
);
	logic led_write;

	assign led_write = !stall && req.write && (req.addr == `LED_ADDR);

	stall_low_after_reset: assert property (@(posedge clk) !rst_n |=> !stall)
		else $error("stall is high in the cycle after reset");

	// A miss spends one cycle in each of the two memory states
	stall_second_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(stall) |=> stall)
		else $error("stall fell after only one cycle");

	stall_two_cycles: assert property (@(posedge clk) disable iff (!rst_n)
		stall && $past(stall) |=> !stall)
		else $error("stall stayed high for more than two cycles");

	led_on_write_only: assert property (@(posedge clk) disable iff (!rst_n)
		!$stable(led) |-> $past(led_write))
		else $error("led changed without an accepted write to the LED address");

endmodule

bind data_mem_cached data_mem_cached_checker u_checker (
	.clk(clk),
	.rst_n(rst_n),
	.req(req),
	.stall(stall),
	.led(led)
);

// ==== data_mem_cached.sv ====
// Cached data memory top: controller, cache lines, selector, aligner and backing store
`include "mem_cache_config.svh"

module data_mem_cached (
	input logic clk,
	input logic rst_n,
	input mem_cache_pkg::mem_req_t req,
	output mem_cache_pkg::word_t read_data,
	output logic stall,
	output logic [7:0] led
);
	import mem_cache_pkg::*;

	mem_req_t cur_req;
	logic use_fill;
	logic line_update;
	logic line_write;
	logic mem_access;
	logic any_hit;
	word_t load_word;
	line_t new_line;
	line_t fill_line;
	line_view_t view;
	mem_index_t fill_index;
	line_vec_t sel;
	line_vec_t hits;
	line_vec_t olds;
	line_vec_t valids;
	line_t line_data [`CACHE_LINES];
	tag_t line_tag [`CACHE_LINES];
	age_t line_age [`CACHE_LINES];

	cache_ctrl u_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.any_hit(any_hit),
		.load_word(load_word),
		.cur_req(cur_req),
		.use_fill(use_fill),
		.line_update(line_update),
		.line_write(line_write),
		.mem_access(mem_access),
		.stall(stall),
		.read_data(read_data),
		.led(led)
	);

	for (genvar i = 0; i < `CACHE_LINES; i++) begin : g_line
		cache_line #(
			.reset_age(age_t'(i))
		) u_line (
			.clk(clk),
			.rst_n(rst_n),
			.cur_addr(cur_req.addr),
			.line_update(line_update),
			.line_write(line_write),
			.sel(sel[i]),
			.accessed_age(view.age),
			.new_line(new_line),
			.data(line_data[i]),
			.tag(line_tag[i]),
			.age(line_age[i]),
			.valid(valids[i]),
			.hit(hits[i])
		);

		assign olds[i] = (line_age[i] == '0);
	end

	line_select u_select (
		.hits(hits),
		.olds(olds),
		.datas(line_data),
		.tags(line_tag),
		.ages(line_age),
		.valids(valids),
		.sel(sel),
		.any_hit(any_hit),
		.view(view)
	);

	load_store_align u_align (
		.cur_req(cur_req),
		.use_fill(use_fill),
		.hit_line(view.data),
		.fill_line(fill_line),
		.load_word(load_word),
		.new_line(new_line)
	);

	// Fill line index relative to the start of the data region
	assign fill_index = mem_index_t'(cur_req.addr[13:4] - tag_t'(`DATA_BASE >> 4));

	line_backing_mem u_mem (
		.clk(clk),
		.mem_access(mem_access),
		.victim(view),
		.fill_index(fill_index),
		.fill_line(fill_line)
	);

endmodule

// ==== cache_ctrl.sv ====
// Cache controller: miss FSM, request buffer, stall, read data and LED registers
`include "mem_cache_config.svh"

module cache_ctrl (
	input logic clk,
	input logic rst_n,
	input mem_cache_pkg::mem_req_t req,
	input logic any_hit,
	input mem_cache_pkg::word_t load_word,
	output mem_cache_pkg::mem_req_t cur_req,
	output logic use_fill,
	output logic line_update,
	output logic line_write,
	output logic mem_access,
	output logic stall,
	output mem_cache_pkg::word_t read_data,
	output logic [7:0] led
);
	import mem_cache_pkg::*;

	cache_state_e state;
	mem_req_t req_buf;
	logic led_sel;
	logic cache_req;
	logic hit_access;

	// The live request is served in IN_CACHE, the buffered copy during a miss
	assign cur_req = (state == IN_CACHE) ? req : req_buf;

	assign led_sel = (req.addr == `LED_ADDR);
	assign cache_req = (state == IN_CACHE) && (req.read || req.write) && !led_sel;
	assign hit_access = cache_req && any_hit;

	assign use_fill = (state == UPDATE_CACHE);
	assign mem_access = (state == ACCESS_MEMORY);
	assign stall = (state != IN_CACHE);

	// A hit refreshes the line age and loads it only on a store, a fill always loads
	assign line_update = hit_access || (state == UPDATE_CACHE);
	assign line_write = (hit_access && req.write) || (state == UPDATE_CACHE);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IN_CACHE;
		end else begin
			case (state)
				IN_CACHE: begin
					if (cache_req && !any_hit) begin
						state <= ACCESS_MEMORY;
					end
				end
				ACCESS_MEMORY: begin
					state <= UPDATE_CACHE;
				end
				UPDATE_CACHE: begin
					state <= IN_CACHE;
				end
				default: begin
					state <= IN_CACHE;
				end
			endcase
		end
	end

	// The buffer follows the input until a miss freezes it
	always_ff @(posedge clk) begin
		if (state == IN_CACHE) begin
			req_buf <= req;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			read_data <= '0;
		end else if (hit_access || (state == UPDATE_CACHE)) begin
			read_data <= load_word;
		end
	end

	// LED writes bypass the cache entirely
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			led <= '0;
		end else if ((state == IN_CACHE) && req.write && led_sel) begin
			led <= req.write_data[7:0];
		end
	end

endmodule

// ==== load_store_align.sv ====
// Byte-lane aligner: extracts and extends load data, merges store data into a line
module load_store_align (
	input mem_cache_pkg::mem_req_t cur_req,
	input logic use_fill,
	input mem_cache_pkg::line_t hit_line,
	input mem_cache_pkg::line_t fill_line,
	output mem_cache_pkg::word_t load_word,
	output mem_cache_pkg::line_t new_line
);
	import mem_cache_pkg::*;

	line_t base_line;
	word_offset_t word_sel;
	word_t old_word;
	word_t store_word;
	logic [7:0] ld_byte;
	logic [15:0] ld_half;

	// During a fill the line comes from the backing store, otherwise from the cache
	assign base_line = use_fill ? fill_line : hit_line;
	assign word_sel = cur_req.addr[3:2];
	assign old_word = base_line[word_sel*32 +: 32];

	assign ld_byte = old_word[cur_req.addr[1:0]*8 +: 8];
	assign ld_half = cur_req.addr[1] ? old_word[31:16] : old_word[15:0];

	always_comb begin
		case (cur_req.size)
			SIZE_BYTE: begin
				load_word = {{24{cur_req.sign_ext & ld_byte[7]}}, ld_byte};
			end
			SIZE_HALF: begin
				load_word = {{16{cur_req.sign_ext & ld_half[15]}}, ld_half};
			end
			default: begin
				load_word = old_word;
			end
		endcase
	end

	// Partial stores keep the untouched bytes of the addressed word
	always_comb begin
		store_word = old_word;
		case (cur_req.size)
			SIZE_BYTE: begin
				store_word[cur_req.addr[1:0]*8 +: 8] = cur_req.write_data[7:0];
			end
			SIZE_HALF: begin
				if (cur_req.addr[1]) begin
					store_word[31:16] = cur_req.write_data[15:0];
				end else begin
					store_word[15:0] = cur_req.write_data[15:0];
				end
			end
			default: begin
				store_word = cur_req.write_data;
			end
		endcase
	end

	always_comb begin
		new_line = base_line;
		if (cur_req.write) begin
			new_line[word_sel*32 +: 32] = store_word;
		end
	end

endmodule

// ==== line_backing_mem.sv ====
// Line-wide backing store: writes back the evicted line and reads the fill line
`include "mem_cache_config.svh"

module line_backing_mem (
	input logic clk,
	input logic mem_access,
	input mem_cache_pkg::line_view_t victim,
	input mem_cache_pkg::mem_index_t fill_index,
	output mem_cache_pkg::line_t fill_line
);
	import mem_cache_pkg::*;

	line_t store [`MEM_LINES];
	mem_index_t victim_index;

	// Line index relative to the start of the data region
	assign victim_index = mem_index_t'(victim.tag - tag_t'(`DATA_BASE >> 4));

	// A miss never selects its own line as victim, so the two indices differ
	always_ff @(posedge clk) begin
		if (mem_access) begin
			if (victim.valid) begin
				store[victim_index] <= victim.data;
			end
			fill_line <= store[fill_index];
		end
	end

endmodule

// ==== line_select.sv ====
// Line selector: picks the hit line or the oldest one and gathers its fields
`include "mem_cache_config.svh"

module line_select (
	input mem_cache_pkg::line_vec_t hits,
	input mem_cache_pkg::line_vec_t olds,
	input mem_cache_pkg::line_t datas [`CACHE_LINES],
	input mem_cache_pkg::tag_t tags [`CACHE_LINES],
	input mem_cache_pkg::age_t ages [`CACHE_LINES],
	input mem_cache_pkg::line_vec_t valids,
	output mem_cache_pkg::line_vec_t sel,
	output logic any_hit,
	output mem_cache_pkg::line_view_t view
);
	import mem_cache_pkg::*;

	assign any_hit = |hits;

	// With no hit the age-0 line is the victim, and exactly one line has age 0
	assign sel = any_hit ? hits : olds;

	// The selection is one-hot, so an AND-OR tree replaces a wide mux
	always_comb begin
		view = '0;
		for (int i = 0; i < `CACHE_LINES; i++) begin
			view.data = view.data | (datas[i] & {$bits(line_t){sel[i]}});
			view.tag = view.tag | (tags[i] & {$bits(tag_t){sel[i]}});
			view.age = view.age | (ages[i] & {$bits(age_t){sel[i]}});
			view.valid = view.valid | (valids[i] & sel[i]);
		end
	end

endmodule

// ==== cache_line.sv ====
// Single cache line with data, tag, valid flag, LRU age and hit compare
`include "mem_cache_config.svh"

module cache_line #(
	parameter mem_cache_pkg::age_t reset_age = '0
) (
	input logic clk,
	input logic rst_n,
	input mem_cache_pkg::byte_addr_t cur_addr,
	input logic line_update,
	input logic line_write,
	input logic sel,
	input mem_cache_pkg::age_t accessed_age,
	input mem_cache_pkg::line_t new_line,
	output mem_cache_pkg::line_t data,
	output mem_cache_pkg::tag_t tag,
	output mem_cache_pkg::age_t age,
	output logic valid,
	output logic hit
);
	import mem_cache_pkg::*;

	tag_t addr_tag;

	assign addr_tag = cur_addr[13:4];
	assign hit = valid && (tag == addr_tag);

	// Ages form a permutation, so each line starts with a distinct one
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			age <= reset_age;
			valid <= 1'b0;
		end else if (line_update) begin
			if (sel) begin
				age <= age_t'(`CACHE_LINES - 1);
				if (line_write) begin
					valid <= 1'b1;
				end
			end else if (age > accessed_age) begin
				// Lines younger than the accessed one move one step towards eviction
				age <= age - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (line_update && line_write && sel) begin
			data <= new_line;
			tag <= addr_tag;
		end
	end

endmodule

// ==== mem_cache_pkg.sv ====
// Cache types: address and data vectors, request and line-view structs, FSM states
`include "mem_cache_config.svh"

package mem_cache_pkg;

	typedef logic [13:0] byte_addr_t;
	typedef logic [31:0] word_t;
	typedef logic [`LINE_WORDS*32-1:0] line_t;

	// Line address, byte address bits 13 down to 4
	typedef logic [9:0] tag_t;
	typedef logic [7:0] mem_index_t;
	typedef logic [1:0] word_offset_t;

	// Age 0 marks the least recently used line
	typedef logic [1:0] age_t;
	typedef logic [`CACHE_LINES-1:0] line_vec_t;

	typedef enum logic [1:0] {
		SIZE_BYTE,
		SIZE_HALF,
		SIZE_WORD
	} access_size_e;

	typedef struct packed {
		logic read;
		logic write;
		byte_addr_t addr;
		word_t write_data;
		access_size_e size;
		logic sign_ext;
	} mem_req_t;

	typedef struct packed {
		line_t data;
		tag_t tag;
		age_t age;
		logic valid;
	} line_view_t;

	typedef enum logic [1:0] {
		IN_CACHE,
		ACCESS_MEMORY,
		UPDATE_CACHE
	} cache_state_e;

endpackage

// ==== mem_cache_config.svh ====
// Cache configuration: line count, line size, backing store depth and address map
`ifndef MEM_CACHE_CONFIG_SVH
`define MEM_CACHE_CONFIG_SVH

// Number of fully associative cache lines
`define CACHE_LINES 4

// 32-bit words held by each cache line
`define LINE_WORDS 4

// Depth of the backing store in lines, 4 KB in total
`define MEM_LINES 256

// First byte address of the cached data region
`define DATA_BASE 14'h1000

// Memory-mapped LED byte, write only
`define LED_ADDR 14'h2000

`endif
